//--- eth_tx_macros.svh
`ifndef ETH_TX_MACROS_SVH
`define ETH_TX_MACROS_SVH

// Payload FIFO, 32-bit words
`define PAYLOAD_DEPTH 64
`define PAYLOAD_AW $clog2(`PAYLOAD_DEPTH)

// Header queue, one entry per committed frame
`define HEADER_DEPTH 4
`define HEADER_AW $clog2(`HEADER_DEPTH)

// Free payload words required before a new frame is admitted
`define MIN_FRAME_WORDS 8

// Frame length in bytes
`define FRAME_LEN_W 14

// MAC address width
`define MAC_W 48

// Any 802.1q tag insertion would widen the header path

`endif

//--- eth_tx_pkg.sv
`default_nettype none

`include "eth_tx_macros.svh"

package eth_tx_pkg;

	// Arbiter side transmit bus
	typedef struct packed {
		logic        start;
		logic        data_valid;
		logic [2:0]  bytes_valid;
		logic [31:0] data;
		logic        commit;
		logic        drop;
	} l2_tx_bus_t;

	// One queued frame header, length first
	typedef struct packed {
		logic [`FRAME_LEN_W-1:0] frame_len;
		logic [15:0]             ethertype;
		logic [`MAC_W-1:0]       dst_mac;
	} tx_header_t;

	// Word stream toward the 10G MAC
	typedef struct packed {
		logic        start;
		logic        data_valid;
		logic [2:0]  bytes_valid;
		logic [31:0] data;
	} tx_frame_t;

	// Transmit sequencer states
	// Three header words, then ethertype, then shifted payload
	typedef enum logic [2:0] {
		IDLE, HDR_READ, HDR_WAIT, DST_HI, DST_SRC, SRC_LO, ETYPE, PAYLOAD
	} seq_state_t;

endpackage

`default_nettype wire

//--- packet_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_tx_macros.svh"

module packet_fifo (
	input  wire logic                  xgmii_tx_clk,
	input  wire logic                  rst_n,

	// Write side, tentative until commit
	input  wire logic                  wr_en,
	input  wire logic [31:0]           wr_data,
	input  wire logic                  commit,
	input  wire logic                  rollback,
	output logic      [`PAYLOAD_AW:0]  wr_free,

	// Read side, addressed from the head of the oldest packet
	input  wire logic                  rd_en,
	input  wire logic [`PAYLOAD_AW-1:0] rd_offset,
	output logic      [31:0]           rd_data,
	output logic      [`PAYLOAD_AW:0]  rd_avail,
	input  wire logic                  pop_packet,
	input  wire logic [`PAYLOAD_AW:0]  pop_words
);

	////////////////////////////////////////////////////////////////////////////
	// Pointers

	// All pointers carry one extra wrap bit
	logic [`PAYLOAD_AW:0]   wr_ptr;
	logic [`PAYLOAD_AW:0]   wr_ptr_next;
	logic [`PAYLOAD_AW:0]   commit_ptr;
	logic [`PAYLOAD_AW:0]   rd_ptr;
	logic [`PAYLOAD_AW-1:0] rd_addr;

	logic [31:0] mem [`PAYLOAD_DEPTH];

	assign wr_ptr_next = wr_en ? wr_ptr + 1'b1 : wr_ptr;

	always_ff @(posedge xgmii_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			commit_ptr <= '0;
			rd_ptr     <= '0;
		end else begin
			// Rollback discards everything past the last commit
			if (rollback)
				wr_ptr <= commit_ptr;
			else
				wr_ptr <= wr_ptr_next;

			// Commit includes a word written in the same cycle
			if (commit)
				commit_ptr <= wr_ptr_next;

			// Whole packet leaves at once
			if (pop_packet)
				rd_ptr <= rd_ptr + pop_words;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Storage

	// Offset read wraps around the ring naturally
	assign rd_addr = rd_ptr[`PAYLOAD_AW-1:0] + rd_offset;

	always_ff @(posedge xgmii_tx_clk) begin
		if (wr_en)
			mem[wr_ptr[`PAYLOAD_AW-1:0]] <= wr_data;
		// One cycle read latency
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

	// Free space counts tentative words as used
	assign wr_free  = (`PAYLOAD_AW+1)'(`PAYLOAD_DEPTH) - (wr_ptr - rd_ptr);

	// Only committed words are readable
	assign rd_avail = commit_ptr - rd_ptr;

	////////////////////////////////////////////////////////////////////////////
	// Checks

	// Writer must abandon a frame before the ring fills
	a_no_write_full: assert property (
		@(posedge xgmii_tx_clk) disable iff (!rst_n)
		wr_en |-> (wr_free != '0)
	) else $error("packet_fifo write with no free space");

	// Sequencer never frees words it has not been given
	a_pop_in_range: assert property (
		@(posedge xgmii_tx_clk) disable iff (!rst_n)
		pop_packet |-> (pop_words <= rd_avail)
	) else $error("packet_fifo pop of %0d words, only %0d committed",
		pop_words, rd_avail);

endmodule

`default_nettype wire

//--- header_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_tx_macros.svh"

module header_fifo import eth_tx_pkg::*; (
	input  wire logic                 xgmii_tx_clk,
	input  wire logic                 rst_n,
	input  wire logic                 push,
	input  wire tx_header_t           push_hdr,
	output logic      [`HEADER_AW:0]  header_free,
	output logic      [`HEADER_AW:0]  header_count,
	input  wire logic                 pop,
	output tx_header_t                head_hdr
);

	logic [`HEADER_AW:0] wr_ptr;
	logic [`HEADER_AW:0] rd_ptr;

	tx_header_t mem [`HEADER_DEPTH];

	// Ring pointers with a wrap bit
	always_ff @(posedge xgmii_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge xgmii_tx_clk) begin
		if (push)
			mem[wr_ptr[`HEADER_AW-1:0]] <= push_hdr;
	end

	// Oldest entry always on view, small enough for a plain mux
	assign head_hdr     = mem[rd_ptr[`HEADER_AW-1:0]];
	assign header_count = wr_ptr - rd_ptr;
	assign header_free  = (`HEADER_AW+1)'(`HEADER_DEPTH) - header_count;

	// Writer admission must have kept a slot for this frame
	a_no_push_full: assert property (
		@(posedge xgmii_tx_clk) disable iff (!rst_n)
		push |-> (header_free != '0)
	) else $error("header_fifo push while full");

	// Sequencer only starts on a queued header
	a_no_pop_empty: assert property (
		@(posedge xgmii_tx_clk) disable iff (!rst_n)
		pop |-> (header_count != '0)
	) else $error("header_fifo pop while empty");

endmodule

`default_nettype wire

//--- l2_ingress_writer.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_tx_macros.svh"

module l2_ingress_writer import eth_tx_pkg::*; (
	input  wire logic                  xgmii_tx_clk,
	input  wire logic                  rst_n,

	// From the layer-2 arbiter
	input  wire l2_tx_bus_t            tx_l2_bus,
	input  wire logic [`MAC_W-1:0]     tx_l2_dst_mac,
	input  wire logic [15:0]           tx_l2_ethertype,

	// Space reports from both FIFOs
	input  wire logic [`PAYLOAD_AW:0]  wr_free,
	input  wire logic [`HEADER_AW:0]   header_free,

	// Packet FIFO write side
	output logic                       wr_en,
	output logic      [31:0]           wr_data,
	output logic                       commit,
	output logic                       rollback,

	// Header queue write side
	output logic                       push,
	output tx_header_t                 push_hdr
);

	logic                    active;
	logic [`FRAME_LEN_W-1:0] frame_len;
	logic                    hdr_room;
	logic                    payload_room;

	// A push in flight has not reached header_free yet
	assign hdr_room     = push ? (header_free > (`HEADER_AW+1)'(1)) : (header_free != '0);
	assign payload_room = (wr_free >= (`PAYLOAD_AW+1)'(`MIN_FRAME_WORDS));

	always_ff @(posedge xgmii_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			active    <= 1'b0;
			frame_len <= '0;
			wr_en     <= 1'b0;
			commit    <= 1'b0;
			rollback  <= 1'b0;
			push      <= 1'b0;
		end else begin
			// Strobes last one cycle
			wr_en    <= 1'b0;
			commit   <= 1'b0;
			rollback <= 1'b0;
			push     <= 1'b0;

			if (!active) begin
				// Refused frames are ignored up to their end
				if (tx_l2_bus.start) begin
					frame_len <= '0;
					active    <= hdr_room && payload_room;
				end
			end else if (tx_l2_bus.commit) begin
				// Payload and header land together
				commit <= 1'b1;
				push   <= 1'b1;
				active <= 1'b0;
			end else if (tx_l2_bus.drop) begin
				rollback <= 1'b1;
				active   <= 1'b0;
			end else if (tx_l2_bus.data_valid) begin
				// wr_free lags one write, so 1 already means full
				if (wr_free <= (`PAYLOAD_AW+1)'(1)) begin
					rollback <= 1'b1;
					active   <= 1'b0;
				end else begin
					wr_en     <= 1'b1;
					frame_len <= frame_len + `FRAME_LEN_W'(tx_l2_bus.bytes_valid);
				end
			end
		end
	end

	// Data path registers
	always_ff @(posedge xgmii_tx_clk) begin
		if (tx_l2_bus.data_valid)
			wr_data <= tx_l2_bus.data;
		if (tx_l2_bus.commit)
			push_hdr <= '{frame_len: frame_len, ethertype: tx_l2_ethertype,
				dst_mac: tx_l2_dst_mac};
	end

endmodule

`default_nettype wire

//--- tx_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_tx_macros.svh"

module tx_sequencer import eth_tx_pkg::*; (
	input  wire logic                   xgmii_tx_clk,
	input  wire logic                   rst_n,
	input  wire logic [`MAC_W-1:0]      our_mac_address,
	input  wire logic                   tx_mac_ready,

	// Header queue read side
	input  wire logic [`HEADER_AW:0]    header_count,
	input  wire tx_header_t             head_hdr,
	output logic                        pop,

	// Packet FIFO read side
	input  wire logic [`PAYLOAD_AW:0]   rd_avail,
	input  wire logic [31:0]            rd_data,
	output logic                        rd_en,
	output logic      [`PAYLOAD_AW-1:0] rd_offset,
	output logic                        pop_packet,
	output logic      [`PAYLOAD_AW:0]   pop_words,

	// To the MAC
	output tx_frame_t                   tx_frame
);

	seq_state_t              state;
	tx_header_t              hdr_q;
	logic [`FRAME_LEN_W-1:0] bytes_left;
	logic [15:0]             prev_lo;
	logic [`FRAME_LEN_W-3:0] len_words;

	// Payload length rounded up to whole words
	assign len_words = hdr_q.frame_len[`FRAME_LEN_W-1:2]
		+ {{(`FRAME_LEN_W-3){1'b0}}, |hdr_q.frame_len[1:0]};

	////////////////////////////////////////////////////////////////////////////
	// Header copy and word history

	// The 14 byte L2 header leaves payload two bytes off word alignment
	// The low half of each word is held for the following output word
	always_ff @(posedge xgmii_tx_clk) begin
		if (state == HDR_READ)
			hdr_q <= head_hdr;
		if (state == ETYPE || state == PAYLOAD)
			prev_lo <= rd_data[15:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge xgmii_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			bytes_left <= '0;
			pop        <= 1'b0;
			rd_en      <= 1'b0;
			rd_offset  <= '0;
			pop_packet <= 1'b0;
			pop_words  <= '0;
			tx_frame   <= '0;
		end else begin
			// Single cycle strobes
			pop                  <= 1'b0;
			rd_en                <= 1'b0;
			pop_packet           <= 1'b0;
			tx_frame.start       <= 1'b0;
			tx_frame.data_valid  <= 1'b0;
			tx_frame.bytes_valid <= 3'd0;

			case (state)
				// MAC readiness matters only between frames
				IDLE: begin
					if (tx_mac_ready && header_count != '0 && rd_avail != '0)
						state <= HDR_READ;
				end
				HDR_READ: state <= HDR_WAIT;
				// Queue slot released once the header copy has settled
				HDR_WAIT: begin
					tx_frame.start <= 1'b1;
					pop            <= 1'b1;
					state          <= DST_HI;
				end
				DST_HI: begin
					tx_frame.data_valid  <= 1'b1;
					tx_frame.bytes_valid <= 3'd4;
					tx_frame.data        <= hdr_q.dst_mac[47:16];
					state                <= DST_SRC;
				end
				// First payload read lands in time for ETYPE
				DST_SRC: begin
					tx_frame.data_valid  <= 1'b1;
					tx_frame.bytes_valid <= 3'd4;
					tx_frame.data        <= {hdr_q.dst_mac[15:0], our_mac_address[47:32]};
					rd_en                <= 1'b1;
					rd_offset            <= '0;
					state                <= SRC_LO;
				end
				SRC_LO: begin
					tx_frame.data_valid  <= 1'b1;
					tx_frame.bytes_valid <= 3'd4;
					tx_frame.data        <= our_mac_address[31:0];
					rd_en                <= 1'b1;
					rd_offset            <= rd_offset + 1'b1;
					state                <= ETYPE;
				end
				// Ethertype plus the first two payload bytes
				ETYPE: begin
					tx_frame.data_valid  <= 1'b1;
					tx_frame.bytes_valid <= 3'd4;
					tx_frame.data        <= {hdr_q.ethertype, rd_data[31:16]};
					bytes_left           <= hdr_q.frame_len - `FRAME_LEN_W'(2);
					rd_en                <= 1'b1;
					rd_offset            <= rd_offset + 1'b1;
					state                <= PAYLOAD;
				end
				PAYLOAD: begin
					tx_frame.data_valid <= 1'b1;
					tx_frame.data       <= {prev_lo, rd_data[31:16]};
					if (bytes_left <= `FRAME_LEN_W'(4)) begin
						// Last word frees the whole packet
						tx_frame.bytes_valid <= bytes_left[2:0];
						pop_packet           <= 1'b1;
						pop_words            <= len_words[`PAYLOAD_AW:0];
						state                <= IDLE;
					end else begin
						tx_frame.bytes_valid <= 3'd4;
						bytes_left           <= bytes_left - `FRAME_LEN_W'(4);
						// Fetch two words ahead while more are still needed
						if (bytes_left > `FRAME_LEN_W'(10)) begin
							rd_en     <= 1'b1;
							rd_offset <= rd_offset + 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks

	a_bytes_valid: assert property (
		@(posedge xgmii_tx_clk) disable iff (!rst_n)
		tx_frame.data_valid |-> (tx_frame.bytes_valid inside {[3'd1:3'd4]})
	) else $error("tx_frame.bytes_valid 0x%0h with data_valid", tx_frame.bytes_valid);

endmodule

`default_nettype wire

//--- eth_tx_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_tx_macros.svh"

module eth_tx_buffer import eth_tx_pkg::*; (
	input  wire logic              xgmii_tx_clk,
	input  wire logic              rst_n,
	input  wire logic [`MAC_W-1:0] our_mac_address,
	input  wire l2_tx_bus_t        tx_l2_bus,
	input  wire logic [`MAC_W-1:0] tx_l2_dst_mac,
	input  wire logic [15:0]       tx_l2_ethertype,
	input  wire logic              tx_mac_ready,
	output tx_frame_t              tx_frame
);

	// Writer to packet FIFO
	logic                    pf_wr_en;
	logic [31:0]             pf_wr_data;
	logic                    pf_commit;
	logic                    pf_rollback;
	logic [`PAYLOAD_AW:0]    pf_wr_free;

	// Sequencer to packet FIFO
	logic                    pf_rd_en;
	logic [`PAYLOAD_AW-1:0]  pf_rd_offset;
	logic [31:0]             pf_rd_data;
	logic [`PAYLOAD_AW:0]    pf_rd_avail;
	logic                    pf_pop_packet;
	logic [`PAYLOAD_AW:0]    pf_pop_words;

	// Header queue
	logic                    hq_push;
	tx_header_t              hq_push_hdr;
	logic [`HEADER_AW:0]     hq_free;
	logic [`HEADER_AW:0]     hq_count;
	logic                    hq_pop;
	tx_header_t              hq_head;

	l2_ingress_writer writer0 (.xgmii_tx_clk, .rst_n, .tx_l2_bus, .tx_l2_dst_mac,
		.tx_l2_ethertype, .wr_free(pf_wr_free), .header_free(hq_free), .wr_en(pf_wr_en),
		.wr_data(pf_wr_data), .commit(pf_commit), .rollback(pf_rollback), .push(hq_push),
		.push_hdr(hq_push_hdr));

	packet_fifo payload_fifo0 (.xgmii_tx_clk, .rst_n, .wr_en(pf_wr_en), .wr_data(pf_wr_data),
		.commit(pf_commit), .rollback(pf_rollback), .wr_free(pf_wr_free), .rd_en(pf_rd_en),
		.rd_offset(pf_rd_offset), .rd_data(pf_rd_data), .rd_avail(pf_rd_avail),
		.pop_packet(pf_pop_packet), .pop_words(pf_pop_words));

	header_fifo header_fifo0 (.xgmii_tx_clk, .rst_n, .push(hq_push), .push_hdr(hq_push_hdr),
		.header_free(hq_free), .header_count(hq_count), .pop(hq_pop), .head_hdr(hq_head));

	tx_sequencer seq0 (.xgmii_tx_clk, .rst_n, .our_mac_address, .tx_mac_ready,
		.header_count(hq_count), .head_hdr(hq_head), .pop(hq_pop), .rd_avail(pf_rd_avail),
		.rd_data(pf_rd_data), .rd_en(pf_rd_en), .rd_offset(pf_rd_offset),
		.pop_packet(pf_pop_packet), .pop_words(pf_pop_words), .tx_frame);

endmodule

`default_nettype wire

//--- tb_eth_tx_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_tx_macros.svh"

module tb_eth_tx_buffer import eth_tx_pkg::*; ();

	localparam int   NUM_ROWS      = 20;
	localparam int   MARGIN_CYCLES = 2000;
	localparam logic ACT_COMMIT    = 1'b0;
	localparam logic ACT_DROP      = 1'b1;

	// One stimulus row, ready is tx_mac_ready while the row is pushed
	typedef struct packed {
		logic [`MAC_W-1:0] dst_mac;
		logic [15:0]       ethertype;
		logic [7:0]        len;
		logic              drop;
		logic              ready;
	} stim_row_t;

	logic              xgmii_tx_clk = 1'b0;
	logic              rst_n;
	logic [`MAC_W-1:0] our_mac_address;
	l2_tx_bus_t        tx_l2_bus;
	logic [`MAC_W-1:0] tx_l2_dst_mac;
	logic [15:0]       tx_l2_ethertype;
	logic              tx_mac_ready;
	tx_frame_t         tx_frame;

	stim_row_t stim [NUM_ROWS];

	// Expected wire bytes of accepted frames, and each frame's total length
	logic [7:0] exp_bytes [$];
	int         exp_len [$];

	integer seed            = 94;
	int     value_errors    = 0;
	int     protocol_errors = 0;
	int     start_count     = 0;
	int     accepted_count  = 0;
	int     wd_cycles       = 0;
	int     cur_left        = 0;
	logic   wd_armed        = 1'b0;
	logic   hold_phase      = 1'b0;
	logic   in_frame        = 1'b0;

	eth_tx_buffer dut0 (.xgmii_tx_clk, .rst_n, .our_mac_address, .tx_l2_bus, .tx_l2_dst_mac,
		.tx_l2_ethertype, .tx_mac_ready, .tx_frame);

	// 4 ns period
	always #2 xgmii_tx_clk = ~xgmii_tx_clk;

	////////////////////////////////////////////////////////////////////////////
	// Reporting

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_problem(input string what);
		protocol_errors++;
		$display("Problem at %0t: %s", $time, what);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Arbiter side driver

	// Start alone, then payload words, then commit or drop alone
	task automatic send_frame(input stim_row_t row, input logic accept);
		logic [7:0]  payload [256];
		logic [31:0] rnd;
		int          k;
		int          j;
		int          n;
		for (k = 0; k < row.len; k++) begin
			rnd = $random(seed);
			payload[k] = rnd[7:0];
		end
		@(posedge xgmii_tx_clk);
		#1;
		tx_l2_bus = '0;
		tx_l2_bus.start = 1'b1;
		for (k = 0; k < row.len; k += 4) begin
			n = (row.len - k > 4) ? 4 : row.len - k;
			@(posedge xgmii_tx_clk);
			#1;
			tx_l2_bus = '0;
			tx_l2_bus.data_valid = 1'b1;
			tx_l2_bus.bytes_valid = n[2:0];
			// Big-endian packing, unused low bytes stay zero
			for (j = 0; j < n; j++)
				tx_l2_bus.data[31-8*j -: 8] = payload[k+j];
		end
		@(posedge xgmii_tx_clk);
		#1;
		tx_l2_bus = '0;
		tx_l2_dst_mac = row.dst_mac;
		tx_l2_ethertype = row.ethertype;
		if (row.drop)
			tx_l2_bus.drop = 1'b1;
		else
			tx_l2_bus.commit = 1'b1;
		// Wire order is dst MAC, our MAC, ethertype, payload
		if (accept) begin
			for (k = 5; k >= 0; k--)
				exp_bytes.push_back(row.dst_mac[8*k +: 8]);
			for (k = 5; k >= 0; k--)
				exp_bytes.push_back(our_mac_address[8*k +: 8]);
			exp_bytes.push_back(row.ethertype[15:8]);
			exp_bytes.push_back(row.ethertype[7:0]);
			for (k = 0; k < row.len; k++)
				exp_bytes.push_back(payload[k]);
			exp_len.push_back(14 + row.len);
		end
		@(posedge xgmii_tx_clk);
		#1;
		tx_l2_bus = '0;
	endtask

	// Release the MAC and wait until every expected frame has left
	task automatic drain_buffer();
		hold_phase = 1'b0;
		tx_mac_ready = 1'b1;
		while (exp_len.size() != 0 || in_frame)
			@(posedge xgmii_tx_clk);
		// Packet pop lands after the last word
		repeat (4) @(posedge xgmii_tx_clk);
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor, sampled mid-cycle

	always @(negedge xgmii_tx_clk) begin : monitor
		int          n;
		int          k;
		logic [31:0] exp_word;
		logic [31:0] mask;
		if (rst_n) begin
			if (hold_phase && (tx_frame.start || tx_frame.data_valid))
				report_problem("output activity while tx_mac_ready is low");
			if (tx_frame.data_valid) begin
				if (!in_frame) begin
					report_problem("data_valid outside a frame");
				end else begin
					n = (cur_left > 4) ? 4 : cur_left;
					exp_word = '0;
					mask = '0;
					for (k = 0; k < n; k++) begin
						exp_word[31-8*k -: 8] = exp_bytes.pop_front();
						mask[31-8*k -: 8] = 8'hff;
					end
					check_value("tx_frame.bytes_valid", tx_frame.bytes_valid, n);
					check_value("tx_frame.data", tx_frame.data & mask, exp_word);
					cur_left -= n;
					if (cur_left == 0)
						in_frame = 1'b0;
				end
			end else if (in_frame) begin
				// Gap inside a frame, give up on the rest of it
				report_problem("data_valid dropped before the end of the frame");
				for (k = 0; k < cur_left; k++)
					void'(exp_bytes.pop_front());
				cur_left = 0;
				in_frame = 1'b0;
			end
			if (tx_frame.start) begin
				start_count++;
				if (in_frame) begin
					report_problem("start pulse inside a frame");
				end else if (exp_len.size() == 0) begin
					report_problem("start pulse with no frame expected");
				end else begin
					cur_left = exp_len.pop_front();
					in_frame = 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Watchdog

	initial begin : watchdog
		wait (wd_armed);
		repeat (wd_cycles) @(posedge xgmii_tx_clk);
		$display("Timeout: the run did not finish within %0d cycles", wd_cycles);
		$display("** FAIL **");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table and main sequence

	initial begin : main
		int   i;
		int   hdr_used;
		int   words_used;
		int   words;
		logic accept;
		logic last_ready;

		// Mixed commits and a drop with the MAC ready
		stim[0]  = {48'h00_11_22_33_44_55, 16'h0800, 8'd46,  ACT_COMMIT, 1'b1};
		stim[1]  = {48'h00_11_22_33_44_66, 16'h86dd, 8'd3,   ACT_COMMIT, 1'b1};
		stim[2]  = {48'h00_11_22_33_44_77, 16'h0806, 8'd17,  ACT_DROP,   1'b1};
		stim[3]  = {48'h00_11_22_33_44_88, 16'h0800, 8'd21,  ACT_COMMIT, 1'b1};
		// MAC held, fifth frame finds the header queue full
		stim[4]  = {48'h0a_00_00_00_00_01, 16'h88b5, 8'd8,   ACT_COMMIT, 1'b0};
		stim[5]  = {48'h0a_00_00_00_00_02, 16'h88b5, 8'd13,  ACT_COMMIT, 1'b0};
		stim[6]  = {48'h0a_00_00_00_00_03, 16'h88b5, 8'd30,  ACT_COMMIT, 1'b0};
		stim[7]  = {48'h0a_00_00_00_00_04, 16'h88b5, 8'd5,   ACT_COMMIT, 1'b0};
		stim[8]  = {48'h0a_00_00_00_00_05, 16'h88b5, 8'd22,  ACT_COMMIT, 1'b0};
		// Short frames back to back
		stim[9]  = {48'hff_ff_ff_ff_ff_ff, 16'h0806, 8'd4,   ACT_COMMIT, 1'b1};
		stim[10] = {48'h01_00_5e_00_00_fb, 16'h0800, 8'd9,   ACT_COMMIT, 1'b1};
		stim[11] = {48'h33_33_00_00_00_01, 16'h86dd, 8'd60,  ACT_COMMIT, 1'b1};
		stim[12] = {48'h00_1b_21_aa_bb_cc, 16'h8100, 8'd6,   ACT_COMMIT, 1'b1};
		// MAC held, 100 byte frame overruns the payload space
		stim[13] = {48'h02_00_00_00_10_01, 16'h0800, 8'd60,  ACT_COMMIT, 1'b0};
		stim[14] = {48'h02_00_00_00_10_02, 16'h0800, 8'd60,  ACT_COMMIT, 1'b0};
		stim[15] = {48'h02_00_00_00_10_03, 16'h0800, 8'd60,  ACT_COMMIT, 1'b0};
		stim[16] = {48'h02_00_00_00_10_04, 16'h0800, 8'd100, ACT_COMMIT, 1'b0};
		stim[17] = {48'h02_00_00_00_10_05, 16'h0800, 8'd40,  ACT_COMMIT, 1'b0};
		// Drop followed by a normal frame
		stim[18] = {48'h00_aa_bb_cc_dd_ee, 16'h88cc, 8'd33,  ACT_DROP,   1'b1};
		stim[19] = {48'h00_aa_bb_cc_dd_ef, 16'h88cc, 8'd12,  ACT_COMMIT, 1'b1};

		rst_n = 1'b0;
		our_mac_address = 48'h02_1a_2b_3c_4d_5e;
		tx_l2_bus = '0;
		tx_l2_dst_mac = '0;
		tx_l2_ethertype = '0;
		tx_mac_ready = 1'b1;

		// Budget of four cycles per wire byte
		wd_cycles = MARGIN_CYCLES;
		for (i = 0; i < NUM_ROWS; i++)
			wd_cycles += (stim[i].len + 14) * 4;
		wd_armed = 1'b1;

		repeat (8) @(posedge xgmii_tx_clk);
		#1;
		rst_n = 1'b1;
		@(negedge xgmii_tx_clk);
		check_value("tx_frame", tx_frame, '0);

		hdr_used = 0;
		words_used = 0;
		last_ready = !stim[0].ready;
		for (i = 0; i < NUM_ROWS; i++) begin
			// New group starts from an empty buffer
			if (stim[i].ready != last_ready) begin
				drain_buffer();
				hdr_used = 0;
				words_used = 0;
				tx_mac_ready = stim[i].ready;
				hold_phase = !stim[i].ready;
				last_ready = stim[i].ready;
			end
			// Admission at start, then overflow, then the arbiter's choice
			words = (stim[i].len + 3) / 4;
			accept = (hdr_used < `HEADER_DEPTH)
				&& (`PAYLOAD_DEPTH - words_used >= `MIN_FRAME_WORDS)
				&& (words <= `PAYLOAD_DEPTH - words_used)
				&& !stim[i].drop;
			send_frame(stim[i], accept);
			if (accept) begin
				hdr_used++;
				words_used += words;
				accepted_count++;
			end
		end
		drain_buffer();

		// Quiet tail catches dropped frames that leak out late
		repeat (64) @(posedge xgmii_tx_clk);
		check_value("start_count", start_count, accepted_count);

		$display("Errors: %0d value, %0d protocol; %0d frames accepted, %0d starts seen",
			value_errors, protocol_errors, accepted_count, start_count);
		if (value_errors == 0 && protocol_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- eth_tx_buffer.f
+incdir+.
eth_tx_pkg.sv
packet_fifo.sv
header_fifo.sv
l2_ingress_writer.sv
tx_sequencer.sv
eth_tx_buffer.sv
tb_eth_tx_buffer.sv
